// ==== rtl/ex_pkg.sv ====
// -------------------------------------------------------------------------
// Shared types of the integer execute stage: ALU operations, data widths
// -------------------------------------------------------------------------

`default_nettype none

package ex_pkg;

  // -------------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------------

  // Datapath width the top level uses unless told otherwise
  localparam int unsigned XLEN_DEFAULT = 32;

  // Operation encoding width
  localparam int unsigned OP_W = 6;

  // Shift amount width at the default datapath width
  localparam int unsigned SHAMT_W = $clog2(XLEN_DEFAULT);

  // Operand and result word at the default width
  typedef logic [XLEN_DEFAULT-1:0] word_t;

  // Shift amount, low bits of operand B
  typedef logic [SHAMT_W-1:0] shamt_t;

  // -------------------------------------------------------------------------
  // Operations
  // -------------------------------------------------------------------------

  // Contiguous encoding, GEU is the last legal value
  typedef enum logic [OP_W-1:0] {
    // Adder
    ADD   = 6'd0,
    SUB   = 6'd1,
    // Logic, with negated B forms
    ANDL  = 6'd2,
    ORL   = 6'd3,
    XORL  = 6'd4,
    ANDN  = 6'd5,
    ORN   = 6'd6,
    XNOR  = 6'd7,
    // Shifts
    SLL   = 6'd8,
    SRL   = 6'd9,
    SRA   = 6'd10,
    // Set less than
    SLTS  = 6'd11,
    SLTU  = 6'd12,
    // Zbb min/max
    MIN   = 6'd13,
    MAX   = 6'd14,
    MINU  = 6'd15,
    MAXU  = 6'd16,
    // Zbb bit counting
    CLZ   = 6'd17,
    CTZ   = 6'd18,
    CPOP  = 6'd19,
    // Zbb extension and rotates
    SEXTB = 6'd20,
    SEXTH = 6'd21,
    ZEXTH = 6'd22,
    ROL   = 6'd23,
    ROR   = 6'd24,
    // Conditional branch compares
    EQ    = 6'd25,
    NE    = 6'd26,
    LTS   = 6'd27,
    LTU   = 6'd28,
    GES   = 6'd29,
    GEU   = 6'd30
  } alu_op_e;

  // True for the six conditional branch compares
  function automatic logic is_branch_op(alu_op_e op);
    return op inside {EQ, NE, LTS, LTU, GES, GEU};
  endfunction

endpackage

`default_nettype wire

// ==== rtl/popcount.sv ====
// -------------------------------------------------------------------------
// Population count over a vector, pairwise adder tree
// -------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module popcount #(
  parameter int unsigned INPUT_WIDTH = 32
) (
  input  logic [INPUT_WIDTH-1:0]       data_i,
  output logic [$clog2(INPUT_WIDTH):0] popcount_o
);

  localparam int unsigned LEVELS = $clog2(INPUT_WIDTH);
  localparam int unsigned PADDED = 1 << LEVELS;
  localparam int unsigned CNT_W  = LEVELS + 1;

  logic [PADDED-1:0] data_pad;

  // Zero padding up to a power of two
  assign data_pad = PADDED'(data_i);

  // Level 0 holds single bits, each higher level halves the node count
  for (genvar l = 0; l <= LEVELS; l++) begin : gen_level
    logic [CNT_W-1:0] sum [PADDED >> l];
    for (genvar n = 0; n < (PADDED >> l); n++) begin : gen_node
      if (l == 0) begin : gen_leaf
        assign sum[n] = CNT_W'(data_pad[n]);
      end else begin : gen_add
        assign sum[n] = gen_level[l-1].sum[2*n] + gen_level[l-1].sum[2*n+1];
      end
    end
  end

  assign popcount_o = gen_level[LEVELS].sum[0];

endmodule

`default_nettype wire

// ==== rtl/lzc.sv ====
// -------------------------------------------------------------------------
// Leading or trailing zero counter with an all-zero flag
// -------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module lzc #(
  // Power of two
  parameter int unsigned WIDTH = 32,
  // 1 counts leading zeros, 0 counts trailing zeros
  parameter bit          MODE  = 1'b0
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int unsigned LEVELS = $clog2(WIDTH);

  logic [WIDTH-1:0] scan;

  // Leading mode scans from the MSB, so tree position 0 is the top bit
  for (genvar i = 0; i < WIDTH; i++) begin : gen_scan
    assign scan[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
  end

  // Priority tree, the lower position wins at each merge
  for (genvar l = 0; l <= LEVELS; l++) begin : gen_level
    logic [(WIDTH >> l)-1:0] hit;
    logic [LEVELS-1:0]       idx [WIDTH >> l];
    for (genvar n = 0; n < (WIDTH >> l); n++) begin : gen_node
      if (l == 0) begin : gen_leaf
        assign hit[n] = scan[n];
        assign idx[n] = LEVELS'(n);
      end else begin : gen_merge
        assign hit[n] = gen_level[l-1].hit[2*n] | gen_level[l-1].hit[2*n+1];
        assign idx[n] = gen_level[l-1].hit[2*n] ? gen_level[l-1].idx[2*n]
                                                : gen_level[l-1].idx[2*n+1];
      end
    end
  end

  // With no set bit the right branch wins everywhere, giving WIDTH-1
  assign cnt_o   = gen_level[LEVELS].idx[0];
  assign empty_o = ~gen_level[LEVELS].hit[0];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// -------------------------------------------------------------------------
// Integer ALU of the execute stage, RV32I plus Zbb, with branch compare
// -------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module alu import ex_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         operation_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            branch_res_o
);

  localparam int unsigned SHW = $clog2(XLEN);

  logic [XLEN-1:0] operand_a_rev;

  // Reversed A feeds left shifts and the trailing zero count
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev_a
    assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
  end

  // -------------------------------------------------------------------------
  // Adder
  // -------------------------------------------------------------------------
  logic            negate_b;
  logic [XLEN:0]   adder_in_a;
  logic [XLEN:0]   adder_in_b;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;
  logic [XLEN-1:0] operand_b_eff;
  logic            adder_zero;

  assign negate_b = operation_i inside {SUB, EQ, NE, ANDN, ORN, XNOR};

  // Ones in the extra LSB supply the +1 of the two's complement
  assign adder_in_a    = {operand_a_i, 1'b1};
  assign adder_in_b    = {operand_b_i, 1'b0} ^ {(XLEN + 1){negate_b}};
  assign adder_sum     = adder_in_a + adder_in_b;
  assign adder_result  = adder_sum[XLEN:1];
  assign operand_b_eff = adder_in_b[XLEN:1];

  // Equality from A minus B
  assign adder_zero = ~|adder_result;

  // -------------------------------------------------------------------------
  // Shifter
  // -------------------------------------------------------------------------
  logic            shift_left;
  logic            shift_arith;
  logic [SHW-1:0]  shift_amt;
  logic [XLEN-1:0] shift_op_a;
  logic [XLEN:0]   shift_right_ext;
  logic [XLEN-1:0] shift_right;
  logic [XLEN-1:0] shift_left_res;
  logic [XLEN-1:0] shift_result;
  logic [XLEN-1:0] rot_left;
  logic [XLEN-1:0] rot_right;

  assign shift_amt   = operand_b_i[SHW-1:0];
  assign shift_left  = (operation_i == SLL);
  assign shift_arith = (operation_i == SRA);

  // Left shift is a right shift of the reversed operand
  assign shift_op_a = shift_left ? operand_a_rev : operand_a_i;

  assign shift_right_ext = $unsigned($signed({shift_arith & shift_op_a[XLEN-1], shift_op_a})
                                     >>> shift_amt);
  assign shift_right = shift_right_ext[XLEN-1:0];

  // Reverse back on the way out
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev_shift
    assign shift_left_res[k] = shift_right[XLEN-1-k];
  end

  assign shift_result = shift_left ? shift_left_res : shift_right;

  // Shift by XLEN yields zero, so amount 0 leaves A unchanged
  assign rot_left  = (operand_a_i << shift_amt) | (operand_a_i >> (XLEN - shift_amt));
  assign rot_right = (operand_a_i >> shift_amt) | (operand_a_i << (XLEN - shift_amt));

  // -------------------------------------------------------------------------
  // Comparator
  // -------------------------------------------------------------------------
  logic cmp_signed;
  logic less;

  assign cmp_signed = operation_i inside {SLTS, LTS, GES, MIN, MAX};

  // One extra bit makes a single signed compare serve both forms
  assign less = $signed({cmp_signed & operand_a_i[XLEN-1], operand_a_i}) <
                $signed({cmp_signed & operand_b_i[XLEN-1], operand_b_i});

  always_comb begin
    case (operation_i)
      EQ:       branch_res_o = adder_zero;
      NE:       branch_res_o = ~adder_zero;
      LTS, LTU: branch_res_o = less;
      GES, GEU: branch_res_o = ~less;
      default:  branch_res_o = 1'b0;
    endcase
  end

  // -------------------------------------------------------------------------
  // Bit counting
  // -------------------------------------------------------------------------
  logic [SHW:0]    cpop;
  logic [XLEN-1:0] lz_in;
  logic [SHW-1:0]  lz_cnt;
  logic            lz_empty;

  // CTZ is CLZ of the reversed operand
  assign lz_in = (operation_i == CTZ) ? operand_a_rev : operand_a_i;

  popcount #(
    .INPUT_WIDTH(XLEN)
  ) popcount_inst (
    .data_i    (operand_a_i),
    .popcount_o(cpop)
  );

  lzc #(
    .WIDTH(XLEN),
    .MODE (1'b1)
  ) lzc_inst (
    .in_i   (lz_in),
    .cnt_o  (lz_cnt),
    .empty_o(lz_empty)
  );

  // -------------------------------------------------------------------------
  // Result mux
  // -------------------------------------------------------------------------
  always_comb begin
    case (operation_i)
      ADD, SUB:    result_o = adder_result;
      ANDL, ANDN:  result_o = operand_a_i & operand_b_eff;
      ORL, ORN:    result_o = operand_a_i | operand_b_eff;
      XORL, XNOR:  result_o = operand_a_i ^ operand_b_eff;
      SLL, SRL, SRA: result_o = shift_result;
      SLTS, SLTU:  result_o = XLEN'(less);
      MIN, MINU:   result_o = less ? operand_a_i : operand_b_i;
      MAX, MAXU:   result_o = less ? operand_b_i : operand_a_i;
      // All-zero input counts the full width
      CLZ, CTZ:    result_o = lz_empty ? XLEN'(XLEN) : XLEN'(lz_cnt);
      CPOP:        result_o = XLEN'(cpop);
      SEXTB:       result_o = {{(XLEN - 8){operand_a_i[7]}}, operand_a_i[7:0]};
      SEXTH:       result_o = {{(XLEN - 16){operand_a_i[15]}}, operand_a_i[15:0]};
      ZEXTH:       result_o = {{(XLEN - 16){1'b0}}, operand_a_i[15:0]};
      ROL:         result_o = rot_left;
      ROR:         result_o = rot_right;
      // Branch compares only drive branch_res_o
      default:     result_o = '0;
    endcase
  end

  // Encodings past GEU are not operations
  always_comb begin
    if (!$isunknown(operation_i)) begin
      a_op_defined: assert (operation_i inside {[ADD:GEU]})
        else $error("alu: undefined operation encoding %0d", operation_i);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
// -------------------------------------------------------------------------
// Branch target and taken decision for conditional branches
// -------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module branch_unit import ex_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         operation_i,
  input  logic [XLEN-1:0] pc_i,
  // Sign-extended branch offset
  input  logic [XLEN-1:0] imm_i,
  // Compare result from the ALU
  input  logic            branch_res_i,
  output logic            is_branch_o,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  logic [XLEN-1:0] target_sum;

  // Target computed for every operation, only meaningful for branches
  assign target_sum = pc_i + imm_i;

  // Bit 0 of a branch target is always zero
  assign target_o = {target_sum[XLEN-1:1], 1'b0};

  always_comb begin
    is_branch_o = is_branch_op(operation_i);
    taken_o     = is_branch_o & branch_res_i;

    // The ALU compare stays low outside the branch compares
    if (!$isunknown({operation_i, branch_res_i})) begin
      a_compare_is_branch: assert (!branch_res_i || is_branch_o)
        else $error("branch_unit: compare result high for a non-branch operation");
    end
  end

endmodule

`default_nettype wire

// ==== rtl/int_exu.sv ====
// -------------------------------------------------------------------------
// Integer execute stage: ALU, branch resolve and one output register
// -------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module int_exu import ex_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Issue side, one cycle per strobe
  input  logic            issue_valid_i,
  input  alu_op_e         operation_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  // Registered outcome, one cycle after the strobe
  output logic            ex_valid_o,
  output logic [XLEN-1:0] ex_result_o,
  output logic            ex_branch_o,
  output logic            ex_taken_o,
  output logic [XLEN-1:0] ex_target_o
);

  if (XLEN < 32 || (XLEN & (XLEN - 1)) != 0) begin : gen_xlen_check
    $error("int_exu: XLEN must be a power of two and at least 32");
  end

  logic [XLEN-1:0] alu_result;
  logic            alu_branch_res;
  logic            is_branch;
  logic            taken;
  logic [XLEN-1:0] target;

  alu #(
    .XLEN(XLEN)
  ) alu_inst (
    .operation_i (operation_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (alu_result),
    .branch_res_o(alu_branch_res)
  );

  branch_unit #(
    .XLEN(XLEN)
  ) branch_unit_inst (
    .operation_i (operation_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .branch_res_i(alu_branch_res),
    .is_branch_o (is_branch),
    .taken_o     (taken),
    .target_o    (target)
  );

  // -------------------------------------------------------------------------
  // Output register
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_valid_o  <= 1'b0;
      ex_result_o <= '0;
      ex_branch_o <= 1'b0;
      ex_taken_o  <= 1'b0;
      ex_target_o <= '0;
    end else begin
      ex_valid_o <= issue_valid_i;
      // Data holds the last strobe between valids
      if (issue_valid_i) begin
        ex_result_o <= alu_result;
        ex_branch_o <= is_branch;
        ex_taken_o  <= taken;
        ex_target_o <= target;
      end
    end
  end

  // Every valid out is backed by a strobe one cycle earlier
  a_valid_follows_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ex_valid_o |-> $past(issue_valid_i)
  ) else $error("int_exu: ex_valid_o without a strobe in the previous cycle");

endmodule

`default_nettype wire

// ==== dv/int_exu_checker.sv ====
// --------------------------------------------------------------------------
// Scoreboard of the execute stage: reference model and cycle-exact compare
// --------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module int_exu_checker import ex_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       issue_valid_i,
  input  alu_op_e    operation_i,
  input  word_t      operand_a_i,
  input  word_t      operand_b_i,
  input  word_t      pc_i,
  input  word_t      imm_i,
  input  logic       ex_valid_i,
  input  word_t      ex_result_i,
  input  logic       ex_branch_i,
  input  logic       ex_taken_i,
  input  word_t      ex_target_i,
  input  logic       test_end_i,
  input  logic [2:0] test_id_i,
  output int         check_count_o,
  output int         error_count_o
);

  typedef struct packed {
    word_t result;
    logic  branch;
    logic  taken;
    word_t target;
  } expect_t;

  expect_t exp_q[$];
  logic    started     = 1'b0;
  logic    reset_win   = 1'b0;
  logic    rst_q       = 1'b1;
  logic    exp_valid   = 1'b0;
  int      checks      = 0;
  int      errors      = 0;
  int      checks_base = 0;
  int      errors_base = 0;

  assign check_count_o = checks;
  assign error_count_o = errors;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic word_t reference_result(alu_op_e op, word_t a, word_t b);
    int unsigned sh;
    word_t       r;
    sh = 32'(b[4:0]);
    r  = '0;
    case (op)
      ADD:   r = a + b;
      SUB:   r = a - b;
      ANDL:  r = a & b;
      ORL:   r = a | b;
      XORL:  r = a ^ b;
      ANDN:  r = a & ~b;
      ORN:   r = a | ~b;
      XNOR:  r = ~(a ^ b);
      SLL:   r = a << sh;
      SRL:   r = a >> sh;
      SRA:   r = word_t'($signed(a) >>> sh);
      SLTS:  r = word_t'($signed(a) < $signed(b));
      SLTU:  r = word_t'(a < b);
      MIN:   r = ($signed(a) < $signed(b)) ? a : b;
      MAX:   r = ($signed(a) < $signed(b)) ? b : a;
      MINU:  r = (a < b) ? a : b;
      MAXU:  r = (a < b) ? b : a;
      SEXTB: r = {{24{a[7]}}, a[7:0]};
      SEXTH: r = {{16{a[15]}}, a[15:0]};
      ZEXTH: r = {16'h0, a[15:0]};
      ROL:   r = (sh == 0) ? a : ((a << sh) | (a >> (32 - sh)));
      ROR:   r = (sh == 0) ? a : ((a >> sh) | (a << (32 - sh)));
      CLZ, CTZ: begin
        // Zero input keeps the full width
        r = 32'd32;
        for (int i = 0; i < 32; i++) begin
          if (op == CLZ && r == 32 && a[31-i]) r = word_t'(i);
          if (op == CTZ && r == 32 && a[i]) r = word_t'(i);
        end
      end
      CPOP: begin
        for (int i = 0; i < 32; i++) r = r + word_t'(a[i]);
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic branch_flag(alu_op_e op);
    case (op)
      EQ, NE, LTS, LTU, GES, GEU: return 1'b1;
      default:                    return 1'b0;
    endcase
  endfunction

  function automatic logic taken_rule(alu_op_e op, word_t a, word_t b);
    case (op)
      EQ:      return a == b;
      NE:      return a != b;
      LTS:     return $signed(a) < $signed(b);
      LTU:     return a < b;
      GES:     return $signed(a) >= $signed(b);
      GEU:     return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd1:    return "reset";
      3'd2:    return "arithmetic and logic";
      3'd3:    return "shifts and rotates";
      3'd4:    return "bit manipulation";
      3'd5:    return "branches";
      default: return "throughput";
    endcase
  endfunction

  task automatic compare(string name, word_t exp, word_t got);
    checks = checks + 1;
    if (exp !== got) begin
      errors = errors + 1;
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // --------------------------------------------------------------------------
  // Inputs sampled on the rising edge, outputs checked on the falling edge
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : sample_inputs
    expect_t e;
    started   = 1'b1;
    // Reset cycles and the first cycle after release
    reset_win = !rst_n_i || !rst_q;
    rst_q     = rst_n_i;
    exp_valid = rst_n_i && issue_valid_i;
    if (exp_valid) begin
      e.result = reference_result(operation_i, operand_a_i, operand_b_i);
      e.branch = branch_flag(operation_i);
      e.taken  = taken_rule(operation_i, operand_a_i, operand_b_i);
      e.target = (pc_i + imm_i) & ~32'h1;
      exp_q.push_back(e);
    end
    if (test_end_i) begin
      $display("Test %0d %s: %0d checks, %0d errors", test_id_i, test_name(test_id_i),
               checks - checks_base, errors - errors_base);
      checks_base = checks;
      errors_base = errors;
    end
  end

  always @(negedge clk_i) begin : check_outputs
    expect_t e;
    if (started) begin
      if (reset_win) begin
        compare("ex_branch_o", '0, 32'(ex_branch_i));
        compare("ex_taken_o", '0, 32'(ex_taken_i));
      end
      compare("ex_valid_o", 32'(exp_valid), 32'(ex_valid_i));
      if (exp_valid && exp_q.size() > 0) begin
        e = exp_q.pop_front();
        compare("ex_branch_o", 32'(e.branch), 32'(ex_branch_i));
        compare("ex_taken_o", 32'(e.taken), 32'(ex_taken_i));
        // Result of a branch compare carries no meaning
        if (e.branch) compare("ex_target_o", e.target, ex_target_i);
        else compare("ex_result_o", e.result, ex_result_i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/int_exu_tb.sv ====
// --------------------------------------------------------------------------
// Testbench of the integer execute stage, random stimulus from xorshift
// --------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module int_exu_tb import ex_pkg::*; ();

  // 763 strobes, up to 3 idle cycles before each of 100 gapped strobes
  localparam int unsigned N_STROBES  = 763;
  localparam int unsigned GAP_CYCLES = 300;
  localparam int unsigned TIMEOUT    = N_STROBES + GAP_CYCLES + 50;

  logic       clk;
  logic       rst_n;
  logic       issue_valid;
  alu_op_e    operation;
  word_t      operand_a;
  word_t      operand_b;
  word_t      pc;
  word_t      imm;
  logic       ex_valid;
  word_t      ex_result;
  logic       ex_branch;
  logic       ex_taken;
  word_t      ex_target;
  logic       test_end;
  logic [2:0] test_id;
  int         check_count;
  int         error_count;
  word_t       rng_state = 32'h4334;
  int unsigned cycle_cnt = 0;

  alu_op_e arith_ops [10] = '{ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR, SLTS, SLTU};
  alu_op_e shift_ops [5]  = '{SLL, SRL, SRA, ROL, ROR};
  alu_op_e bit_ops   [10] = '{CLZ, CTZ, CPOP, MIN, MAX, MINU, MAXU, SEXTB, SEXTH, ZEXTH};
  alu_op_e branch_ops[6]  = '{EQ, NE, LTS, LTU, GES, GEU};

  int_exu #(
    .XLEN(XLEN_DEFAULT)
  ) int_exu_inst (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .issue_valid_i(issue_valid),
    .operation_i  (operation),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .pc_i         (pc),
    .imm_i        (imm),
    .ex_valid_o   (ex_valid),
    .ex_result_o  (ex_result),
    .ex_branch_o  (ex_branch),
    .ex_taken_o   (ex_taken),
    .ex_target_o  (ex_target)
  );

  int_exu_checker int_exu_checker_inst (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .issue_valid_i(issue_valid),
    .operation_i  (operation),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .pc_i         (pc),
    .imm_i        (imm),
    .ex_valid_i   (ex_valid),
    .ex_result_i  (ex_result),
    .ex_branch_i  (ex_branch),
    .ex_taken_i   (ex_taken),
    .ex_target_i  (ex_target),
    .test_end_i   (test_end),
    .test_id_i    (test_id),
    .check_count_o(check_count),
    .error_count_o(error_count)
  );

  function automatic word_t xorshift32(word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int rand_below(int unsigned n);
    return int'(next_random() % n);
  endfunction

  // Corner operands on about half the draws
  function automatic word_t pick_operand();
    word_t sel;
    sel = next_random();
    case (sel[2:0])
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h7fff_ffff;
      default: return next_random();
    endcase
  endfunction

  // One strobe, driven right after a falling edge
  task automatic issue(alu_op_e op, word_t a, word_t b, word_t p, word_t i);
    issue_valid = 1'b1;
    operation   = op;
    operand_a   = a;
    operand_b   = b;
    pc          = p;
    imm         = i;
    @(negedge clk);
  endtask

  task automatic idle(int n);
    issue_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // Drain the stage, then flag the end of a test to the checker
  task automatic end_test(int id);
    idle(2);
    test_id  = 3'(id);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin : stimulus
    word_t r;
    word_t a;
    word_t b;
    word_t p;
    word_t i;
    rst_n       = 1'b0;
    // Taken branch strobes during reset, which the reset must override
    issue_valid = 1'b1;
    operation   = EQ;
    operand_a   = '0;
    operand_b   = '0;
    pc          = '0;
    imm         = '0;
    test_end    = 1'b0;
    test_id     = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    end_test(1);

    for (int n = 0; n < 200; n++) begin
      issue(arith_ops[rand_below(10)], pick_operand(), pick_operand(), '0, '0);
    end
    end_test(2);

    // Amounts 0 and 31 for every shift, then random amounts
    for (int k = 0; k < 5; k++) begin
      issue(shift_ops[k], pick_operand(), 32'd0, '0, '0);
      issue(shift_ops[k], pick_operand(), 32'd31, '0, '0);
    end
    for (int n = 0; n < 100; n++) begin
      r = next_random();
      b = next_random();
      if (r[1:0] == 2'd0) b[4:0] = 5'd0;
      else if (r[1:0] == 2'd1) b[4:0] = 5'd31;
      issue(shift_ops[rand_below(5)], pick_operand(), b, '0, '0);
    end
    end_test(3);

    issue(CLZ, '0, '0, '0, '0);
    issue(CTZ, '0, '0, '0, '0);
    issue(CPOP, '0, '0, '0, '0);
    for (int n = 0; n < 100; n++) begin
      issue(bit_ops[rand_below(10)], pick_operand(), pick_operand(), '0, '0);
    end
    end_test(4);

    // Mostly branches, every fourth a non-branch op
    for (int n = 0; n < 150; n++) begin
      r = next_random();
      a = pick_operand();
      b = r[2] ? a : pick_operand();
      p = next_random();
      p[1:0] = 2'b00;
      i = next_random();
      i = {{19{i[12]}}, i[12:1], 1'b0};
      if (r[4:3] == 2'd0) issue(alu_op_e'(6'(rand_below(25))), a, b, p, i);
      else issue(branch_ops[rand_below(6)], a, b, p, i);
    end
    end_test(5);

    for (int n = 0; n < 100; n++) begin
      issue(alu_op_e'(6'(rand_below(31))), pick_operand(), pick_operand(),
            next_random(), next_random());
    end
    for (int n = 0; n < 100; n++) begin
      idle(rand_below(4));
      issue(alu_op_e'(6'(rand_below(31))), pick_operand(), pick_operand(),
            next_random(), next_random());
    end
    end_test(6);

    // Counts settle after the last falling edge compare
    @(posedge clk);
    $display("Totals: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== int_exu.f ====
rtl/ex_pkg.sv
rtl/popcount.sv
rtl/lzc.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/int_exu.sv
dv/int_exu_checker.sv
dv/int_exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f int_exu.f --top-module int_exu_tb -o int_exu_sim \
  && ./obj_dir/int_exu_sim | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
